// ==== include/rsu_macros.svh ====
// Remote update widths and codes
`ifndef RSU_MACROS_SVH
`define RSU_MACROS_SVH

// User data bus
`define RSU_DATA_W        32
// Control and update register image
`define RSU_IMAGE_W       46
// Trigger status field
`define RSU_STATUS_W      5
// Status and image together on the serial chain
`define RSU_CAPTURE_W     51
// Watchdog timeout field
`define RSU_WD_W          12
// Wide enough to count a full 51 bit shift
`define RSU_COUNT_W       6

// User parameter codes
// 001, 110 and 111 stay illegal
`define RSU_P_STATUS      3'b000
`define RSU_P_WD_TIMEOUT  3'b010
`define RSU_P_WD_ENABLE   3'b011
`define RSU_P_BOOT_ADDR   3'b100
`define RSU_P_ANF         3'b101
// Internal select for the read after reset
`define RSU_P_RESET_READ  4'b1000

// Field positions in the image
`define RSU_IMG_WD_MSB    45
`define RSU_IMG_WD_LSB    34
`define RSU_IMG_WD_EN     33
`define RSU_IMG_ADDR_MSB  32
`define RSU_IMG_ADDR_LSB  1
`define RSU_IMG_ANF       0

`endif

// ==== src/rsu_pkg.sv ====
// Remote update types
`default_nettype none

`include "rsu_macros.svh"

package rsu_pkg;

    // Plain vectors with a meaning
    typedef logic [`RSU_DATA_W-1:0]    data_t;
    typedef logic [2:0]                param_t;
    // User code with a leading zero, or 1000 for the reset read
    typedef logic [3:0]                param_sel_t;
    typedef logic [`RSU_WD_W-1:0]      wd_timeout_t;
    typedef logic [`RSU_DATA_W-1:0]    boot_addr_t;
    typedef logic [`RSU_STATUS_W-1:0]  status_t;
    typedef logic [`RSU_IMAGE_W-1:0]   image_t;
    typedef logic [`RSU_CAPTURE_W-1:0] capture_t;
    typedef logic [`RSU_COUNT_W-1:0]   bit_count_t;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,
        CAPTURE_REGS,
        CAPTURE_UPDATE,
        SHIFT_IN,
        SHIFT_OUT,
        UPDATE
    } rsu_state_e;

    // Update block control encoding
    typedef enum logic [1:0] {
        CTL_SHIFT           = 2'b00,
        CTL_UPDATE          = 2'b01,
        CTL_CAPTURE_UPDATE  = 2'b10,
        CTL_CAPTURE_CONTROL = 2'b11
    } ru_ctl_e;

    // Writable fields, MSB first in image order
    typedef struct packed {
        wd_timeout_t wd_timeout;
        logic        wd_enable;
        boot_addr_t  boot_addr;
        logic        anf;
    } shadow_t;

    // Pins toward the update block
    typedef struct packed {
        ru_ctl_e ctl;
        logic    regin;
        logic    rconfig;
        logic    rsttimer;
    } ru_pins_t;

endpackage

`default_nettype wire

// ==== src/rsu_sequencer.sv ====
// Remote update sequencer
`timescale 1ns/1ps
`default_nettype none

`include "rsu_macros.svh"

module rsu_sequencer import rsu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       write_param,
    input  logic       read_param,
    input  param_t     param,
    input  logic       ctl_nupdt,
    input  logic       reconfig,
    input  logic       reset_timer,
    input  logic       shift_out_done,
    output logic       write_accept,
    output param_sel_t param_sel,
    output bit_count_t bit_count,
    output logic       shift_out_en,
    output logic       shift_in_en,
    output logic       image_valid,
    output ru_ctl_e    ru_ctl,
    output logic       rconfig,
    output logic       rsttimer,
    output logic       busy
);

    rsu_state_e state;
    rsu_state_e next_state;
    logic       read_req;
    logic       write_req;
    logic       read_accept;
    logic       idle_free;
    logic       reset_trigger;
    logic       reset_sync;
    logic       post_read;
    logic       done_q;
    logic       shift_in_done;

    // Two stage trigger, starts the update register read after reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            reset_trigger <= 1'b1;
            reset_sync    <= 1'b1;
        end else begin
            reset_trigger <= reset_sync;
            reset_sync    <= 1'b0;
        end
    end

    // Requests only land in a quiet IDLE
    assign idle_free    = (state == IDLE) && !busy;
    assign read_accept  = read_param && idle_free;
    // Read wins over write
    assign write_accept = write_param && idle_free && !read_param;

    // Request flags hold through the operation, drop in the first IDLE cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            read_req  <= 1'b0;
            write_req <= 1'b0;
        end else if (read_accept || write_accept) begin
            read_req  <= read_accept;
            write_req <= write_accept;
        end else if (state == IDLE) begin
            read_req  <= 1'b0;
            write_req <= 1'b0;
        end
    end

    // Select follows the user code, reset read takes the whole chain
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            param_sel <= '0;
        end else if (state == CAPTURE_UPDATE) begin
            param_sel <= `RSU_P_RESET_READ;
        end else if (read_accept || write_accept) begin
            param_sel <= {1'b0, param};
        end
    end

    // Post-reset read tracking and shadow load strobe
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            post_read   <= 1'b0;
            done_q      <= 1'b0;
            image_valid <= 1'b0;
        end else begin
            done_q      <= shift_out_done;
            image_valid <= done_q && post_read;
            if (state == CAPTURE_UPDATE) begin
                post_read <= 1'b1;
            end else if (done_q) begin
                post_read <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (reset_trigger) begin
                    next_state = CAPTURE_UPDATE;
                end else if (read_accept) begin
                    next_state = CAPTURE_REGS;
                end else if (write_accept) begin
                    next_state = SHIFT_IN;
                end
            end
            CAPTURE_REGS:   next_state = SHIFT_OUT;
            CAPTURE_UPDATE: next_state = SHIFT_OUT;
            SHIFT_OUT: begin
                if (shift_out_done) begin
                    next_state = IDLE;
                end
            end
            SHIFT_IN: begin
                if (shift_in_done) begin
                    next_state = UPDATE;
                end
            end
            UPDATE:         next_state = IDLE;
            default:        next_state = IDLE;
        endcase
    end

    assign shift_out_en = (state == SHIFT_OUT);
    assign shift_in_en  = (state == SHIFT_IN);

    // Counts shift cycles, zero outside the shift states
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bit_count <= '0;
        end else if (shift_out_en || shift_in_en) begin
            bit_count <= bit_count + 1'b1;
        end else begin
            bit_count <= '0;
        end
    end

    // First shift-in cycle primes the image shifter
    // Image bit k goes out while the count is k+1, so stop at 46
    assign shift_in_done = write_req && (bit_count == bit_count_t'(`RSU_IMAGE_W));

    always_comb begin
        case (state)
            CAPTURE_UPDATE: ru_ctl = CTL_CAPTURE_UPDATE;
            SHIFT_OUT,
            SHIFT_IN:       ru_ctl = CTL_SHIFT;
            UPDATE:         ru_ctl = CTL_UPDATE;
            // IDLE and CAPTURE_REGS follow the user register choice
            default:        ru_ctl = ctl_nupdt ? CTL_CAPTURE_CONTROL : CTL_CAPTURE_UPDATE;
        endcase
    end

    assign busy = (state != IDLE) || reset_trigger || post_read || image_valid ||
                  read_req || write_req;

    // Strobes pass straight through only while idle
    assign rconfig  = reconfig && (state == IDLE);
    assign rsttimer = reset_timer && (state == IDLE);

endmodule

`default_nettype wire

// ==== src/rsu_shadow_regs.sv ====
// Shadow field registers and image shifter
`timescale 1ns/1ps
`default_nettype none

`include "rsu_macros.svh"

module rsu_shadow_regs import rsu_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     write_accept,
    input  param_t   param,
    input  data_t    data_in,
    input  logic     image_valid,
    input  capture_t captured,
    input  logic     shift_in_en,
    output logic     regin
);

    shadow_t shadow_q;
    image_t  image_q;
    logic    shift_q;

    // Local copy of every writable field
    // A write only touches its own field, the rest is rebuilt on each shift-in
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            shadow_q <= '0;
        end else if (write_accept) begin
            case (param)
                `RSU_P_WD_TIMEOUT: shadow_q.wd_timeout <= data_in[`RSU_WD_W-1:0];
                `RSU_P_WD_ENABLE:  shadow_q.wd_enable  <= data_in[0];
                `RSU_P_BOOT_ADDR:  shadow_q.boot_addr  <= data_in;
                `RSU_P_ANF:        shadow_q.anf        <= data_in[0];
                // Status is read only
                default:           shadow_q            <= shadow_q;
            endcase
        end else if (image_valid) begin
            // Update register contents from the read after reset
            shadow_q.wd_timeout <= captured[`RSU_IMG_WD_MSB:`RSU_IMG_WD_LSB];
            shadow_q.wd_enable  <= captured[`RSU_IMG_WD_EN];
            shadow_q.boot_addr  <= captured[`RSU_IMG_ADDR_MSB:`RSU_IMG_ADDR_LSB];
            shadow_q.anf        <= captured[`RSU_IMG_ANF];
        end
    end

    // Enable lags one cycle behind the counter
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            shift_q <= 1'b0;
        end else begin
            shift_q <= shift_in_en;
        end
    end

    // Reloads from the shadows when not shifting
    // LSB leaves first toward the update register MSB
    always_ff @(posedge clock) begin
        if (shift_q) begin
            image_q <= {1'b0, image_q[`RSU_IMAGE_W-1:1]};
        end else begin
            image_q <= image_t'(shadow_q);
        end
    end

    assign regin = image_q[0];

endmodule

`default_nettype wire

// ==== src/rsu_readout.sv ====
// Serial readout and field decode
`timescale 1ns/1ps
`default_nettype none

`include "rsu_macros.svh"

module rsu_readout import rsu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       shift_out_en,
    input  param_sel_t param_sel,
    input  bit_count_t bit_count,
    input  logic       regout,
    output logic       shift_out_done,
    output capture_t   captured,
    output data_t      data_out
);

    bit_count_t stop_count;
    logic       sel_legal;
    logic       done_q;
    capture_t   capture_q;
    capture_t   held_q;
    param_sel_t held_sel;

    // Serial order from the update block: image bit 0 first, status bit 4 last
    // Stop once the wanted field's last bit has arrived
    always_comb begin
        sel_legal  = 1'b1;
        stop_count = '0;
        case (param_sel)
            {1'b0, `RSU_P_STATUS}:     stop_count = bit_count_t'(`RSU_CAPTURE_W - 1);
            {1'b0, `RSU_P_WD_TIMEOUT}: stop_count = bit_count_t'(`RSU_IMG_WD_MSB);
            {1'b0, `RSU_P_WD_ENABLE}:  stop_count = bit_count_t'(`RSU_IMG_WD_EN);
            {1'b0, `RSU_P_BOOT_ADDR}:  stop_count = bit_count_t'(`RSU_IMG_ADDR_MSB);
            {1'b0, `RSU_P_ANF}:        stop_count = bit_count_t'(`RSU_IMG_ANF);
            // Whole chain for the shadow load
            `RSU_P_RESET_READ:         stop_count = bit_count_t'(`RSU_CAPTURE_W - 1);
            // Illegal code, finish at once
            default:                   sel_legal  = 1'b0;
        endcase
    end

    assign shift_out_done = shift_out_en && (!sel_legal || (bit_count == stop_count));

    // Bits enter at the top and walk down
    always_ff @(posedge clock) begin
        if (shift_out_en && sel_legal) begin
            capture_q <= {regout, capture_q[`RSU_CAPTURE_W-1:1]};
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            done_q <= 1'b0;
        end else begin
            done_q <= shift_out_done;
        end
    end

    // Held copy stays until the next read completes
    always_ff @(posedge clock) begin
        if (done_q) begin
            held_q <= capture_q;
        end
    end

    // Select of the held copy, decodes to zero until a user read
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            held_sel <= `RSU_P_RESET_READ;
        end else if (done_q) begin
            held_sel <= param_sel;
        end
    end

    assign captured = held_q;

    // Field sits in the top bits, zero extended to the bus
    always_comb begin
        case (held_sel)
            {1'b0, `RSU_P_STATUS}:
                data_out = data_t'(held_q[`RSU_CAPTURE_W-1 -: `RSU_STATUS_W]);
            {1'b0, `RSU_P_WD_TIMEOUT}:
                data_out = data_t'(held_q[`RSU_CAPTURE_W-1 -: `RSU_WD_W]);
            {1'b0, `RSU_P_WD_ENABLE}:
                data_out = data_t'(held_q[`RSU_CAPTURE_W-1]);
            {1'b0, `RSU_P_BOOT_ADDR}:
                data_out = held_q[`RSU_CAPTURE_W-1 -: `RSU_DATA_W];
            {1'b0, `RSU_P_ANF}:
                data_out = data_t'(held_q[`RSU_CAPTURE_W-1]);
            // Illegal codes and the reset read
            default:
                data_out = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/rsu_top.sv ====
// Remote update controller
`timescale 1ns/1ps
`default_nettype none

module rsu_top import rsu_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  data_t    data_in,
    input  param_t   param,
    input  logic     write_param,
    input  logic     read_param,
    // High selects the control register, low the update register
    input  logic     ctl_nupdt,
    input  logic     reconfig,
    input  logic     reset_timer,
    output data_t    data_out,
    output logic     busy,
    // Update block pins
    output ru_pins_t ru_pins,
    input  logic     regout
);

    logic       write_accept;
    param_sel_t param_sel;
    bit_count_t bit_count;
    logic       shift_out_en;
    logic       shift_in_en;
    logic       shift_out_done;
    logic       image_valid;
    capture_t   captured;
    ru_ctl_e    ru_ctl;
    logic       regin;
    logic       rconfig;
    logic       rsttimer;

    rsu_sequencer i_rsu_sequencer (
        .clock          (clock),
        .reset          (reset),
        .write_param    (write_param),
        .read_param     (read_param),
        .param          (param),
        .ctl_nupdt      (ctl_nupdt),
        .reconfig       (reconfig),
        .reset_timer    (reset_timer),
        .shift_out_done (shift_out_done),
        .write_accept   (write_accept),
        .param_sel      (param_sel),
        .bit_count      (bit_count),
        .shift_out_en   (shift_out_en),
        .shift_in_en    (shift_in_en),
        .image_valid    (image_valid),
        .ru_ctl         (ru_ctl),
        .rconfig        (rconfig),
        .rsttimer       (rsttimer),
        .busy           (busy)
    );

    // Shift out path from the update block
    rsu_readout i_rsu_readout (
        .clock          (clock),
        .reset          (reset),
        .shift_out_en   (shift_out_en),
        .param_sel      (param_sel),
        .bit_count      (bit_count),
        .regout         (regout),
        .shift_out_done (shift_out_done),
        .captured       (captured),
        .data_out       (data_out)
    );

    // Shift in path toward the update block
    rsu_shadow_regs i_rsu_shadow_regs (
        .clock          (clock),
        .reset          (reset),
        .write_accept   (write_accept),
        .param          (param),
        .data_in        (data_in),
        .image_valid    (image_valid),
        .captured       (captured),
        .shift_in_en    (shift_in_en),
        .regin          (regin)
    );

    assign ru_pins = '{ctl: ru_ctl, regin: regin, rconfig: rconfig, rsttimer: rsttimer};

endmodule

`default_nettype wire

// ==== bench/rsu_ru_model.sv ====
// Remote update block model
`timescale 1ns/1ps
`default_nettype none

module rsu_ru_model import rsu_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  status_t  init_status,
    input  image_t   init_image,
    input  ru_pins_t ru_pins,
    output logic     regout
);

    status_t  status_q;
    image_t   update_q;
    image_t   control_q;
    // Out path toward the controller, image bit 0 leaves first
    capture_t out_q;
    // In path from the controller, regin enters at the image MSB
    image_t   in_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            status_q  <= init_status;
            update_q  <= init_image;
            control_q <= init_image;
            out_q     <= '0;
            in_q      <= '0;
        end else begin
            case (ru_pins.ctl)
                CTL_SHIFT: begin
                    out_q <= {1'b0, out_q[`RSU_CAPTURE_W-1:1]};
                    in_q  <= {ru_pins.regin, in_q[`RSU_IMAGE_W-1:1]};
                end
                CTL_CAPTURE_UPDATE:  out_q <= {status_q, update_q};
                CTL_CAPTURE_CONTROL: out_q <= {status_q, control_q};
                // New image goes to both registers
                default: begin
                    update_q  <= in_q;
                    control_q <= in_q;
                end
            endcase
        end
    end

    assign regout = out_q[0];

endmodule

`default_nettype wire

// ==== bench/rsu_checker.sv ====
// Remote update pin assertions
`timescale 1ns/1ps
`default_nettype none

module rsu_checker import rsu_pkg::*; (
    input logic     clock,
    input logic     reset,
    input logic     busy,
    input logic     write_accept,
    input ru_pins_t ru_pins
);

    logic write_seen;

    // Set by an accepted write, used up by its update cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_seen <= 1'b0;
        end else if (write_accept) begin
            write_seen <= 1'b1;
        end else if (ru_pins.ctl == CTL_UPDATE) begin
            write_seen <= 1'b0;
        end
    end

    busy_after_reset: assert property (@(posedge clock) $fell(reset) |-> busy)
        else $error("busy low right after reset release");

    // Strobes stay quiet during shifting and update
    strobes_gated: assert property (@(posedge clock) disable iff (reset)
        (ru_pins.ctl == CTL_SHIFT || ru_pins.ctl == CTL_UPDATE) |->
        (!ru_pins.rconfig && !ru_pins.rsttimer))
        else $error("strobe passed while the update block was busy");

    update_needs_write: assert property (@(posedge clock) disable iff (reset)
        (ru_pins.ctl == CTL_UPDATE) |-> write_seen)
        else $error("update cycle without a write");

endmodule

bind rsu_top rsu_checker i_rsu_checker (
    .clock        (clock),
    .reset        (reset),
    .busy         (busy),
    .write_accept (write_accept),
    .ru_pins      (ru_pins)
);

`default_nettype wire

// ==== bench/rsu_tb.sv ====
// Remote update controller testbench
`timescale 1ns/1ps
`default_nettype none

`include "rsu_macros.svh"

module rsu_tb import rsu_pkg::*; ();

    logic       clock;
    logic       reset;
    data_t      data_in;
    param_t     param;
    logic       write_param;
    logic       read_param;
    logic       ctl_nupdt;
    logic       reconfig;
    logic       reset_timer;
    data_t      data_out;
    logic       busy;
    ru_pins_t   ru_pins;
    logic       regout;
    status_t    init_status;
    image_t     init_image;

    // Expected field values
    status_t     exp_status;
    wd_timeout_t exp_timeout;
    logic        exp_enable;
    boot_addr_t  exp_addr;
    logic        exp_anf;

    // Operations from the vector file
    string       op_q[$];
    logic [31:0] param_q[$];
    logic [31:0] data_q[$];
    logic [31:0] nupdt_q[$];
    logic [31:0] exp_q[$];

    int          cycles;
    int          cycle_limit;
    int          fd;
    int          got_init;
    int          fields;
    string       line;
    string       op_name;
    logic [31:0] v0, v1, v2, v3, v4;

    rsu_top i_rsu_top (
        .clock       (clock),
        .reset       (reset),
        .data_in     (data_in),
        .param       (param),
        .write_param (write_param),
        .read_param  (read_param),
        .ctl_nupdt   (ctl_nupdt),
        .reconfig    (reconfig),
        .reset_timer (reset_timer),
        .data_out    (data_out),
        .busy        (busy),
        .ru_pins     (ru_pins),
        .regout      (regout)
    );

    rsu_ru_model i_rsu_ru_model (
        .clock       (clock),
        .reset       (reset),
        .init_status (init_status),
        .init_image  (init_image),
        .ru_pins     (ru_pins),
        .regout      (regout)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Ends a hung run
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: operation did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    // Field value as a read should return it
    function automatic logic [31:0] field_value(input logic [31:0] p);
        case (p[2:0])
            `RSU_P_STATUS:     field_value = 32'(exp_status);
            `RSU_P_WD_TIMEOUT: field_value = 32'(exp_timeout);
            `RSU_P_WD_ENABLE:  field_value = 32'(exp_enable);
            `RSU_P_BOOT_ADDR:  field_value = exp_addr;
            `RSU_P_ANF:        field_value = 32'(exp_anf);
            default:           field_value = 32'h0;
        endcase
    endfunction

    task automatic wait_idle();
        do begin
            @(negedge clock);
        end while (busy);
    endtask

    task automatic run_read(input int idx, input logic [31:0] p, input logic n,
                            input logic [31:0] file_exp);
        logic [31:0] expected;
        string       name;
        expected = field_value(p);
        name = $sformatf("read %0d param %0d", idx, p[2:0]);
        check_value({name, " vector"}, expected, file_exp);
        @(posedge clock);
        param      <= p[2:0];
        ctl_nupdt  <= n;
        read_param <= 1'b1;
        // Junk write and strobes while busy must all be ignored
        @(posedge clock);
        read_param  <= 1'b0;
        write_param <= 1'b1;
        data_in     <= ~expected;
        reconfig    <= 1'b1;
        reset_timer <= 1'b1;
        // Held through the capture cycle and into the first shift cycle
        repeat (2) begin
            @(negedge clock);
            check_value({name, " busy"}, 32'h1, 32'(busy));
            check_value({name, " rconfig"}, 32'h0, 32'(ru_pins.rconfig));
            check_value({name, " rsttimer"}, 32'h0, 32'(ru_pins.rsttimer));
            @(posedge clock);
        end
        write_param <= 1'b0;
        reconfig    <= 1'b0;
        reset_timer <= 1'b0;
        wait_idle();
        check_value({name, " data"}, expected, data_out);
    endtask

    task automatic run_write(input logic [31:0] p, input logic [31:0] d);
        @(posedge clock);
        param       <= p[2:0];
        data_in     <= d;
        write_param <= 1'b1;
        @(posedge clock);
        write_param <= 1'b0;
        wait_idle();
        case (p[2:0])
            `RSU_P_WD_TIMEOUT: exp_timeout = d[`RSU_WD_W-1:0];
            `RSU_P_WD_ENABLE:  exp_enable  = d[0];
            `RSU_P_BOOT_ADDR:  exp_addr    = d;
            `RSU_P_ANF:        exp_anf     = d[0];
            // Status is read only
            default:           exp_anf     = exp_anf;
        endcase
    endtask

    // Idle strobe shows on the pins in the same cycle
    task automatic pulse_strobe(input int idx, input logic is_reconfig);
        string name;
        name = $sformatf("strobe %0d", idx);
        @(posedge clock);
        reconfig    <= is_reconfig;
        reset_timer <= !is_reconfig;
        @(negedge clock);
        check_value({name, " rconfig"}, 32'(is_reconfig), 32'(ru_pins.rconfig));
        check_value({name, " rsttimer"}, 32'(!is_reconfig), 32'(ru_pins.rsttimer));
        // Idle control code follows the register choice
        check_value({name, " ctl"},
                    ctl_nupdt ? 32'(CTL_CAPTURE_CONTROL) : 32'(CTL_CAPTURE_UPDATE),
                    32'(ru_pins.ctl));
        @(posedge clock);
        reconfig    <= 1'b0;
        reset_timer <= 1'b0;
    endtask

    initial begin
        reset       = 1'b1;
        data_in     = '0;
        param       = '0;
        write_param = 1'b0;
        read_param  = 1'b0;
        ctl_nupdt   = 1'b0;
        reconfig    = 1'b0;
        reset_timer = 1'b0;
        init_status = '0;
        init_image  = '0;
        cycles      = 0;
        cycle_limit = 100000;
        got_init    = 0;
        fd = $fopen("bench/rsu_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file");
            $display("=== FAIL ===");
            $fatal(1, "missing vectors");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (got_init == 0) begin
                fields = $sscanf(line, "%h %h %h %h %h", v0, v1, v2, v3, v4);
                if (fields != 5) begin
                    $display("Initial register line in the vector file is incomplete");
                    $display("=== FAIL ===");
                    $fatal(1, "bad vector file");
                end
                init_status = v0[`RSU_STATUS_W-1:0];
                init_image  = {v1[`RSU_WD_W-1:0], v2[0], v3, v4[0]};
                got_init    = 1;
            end else begin
                fields = $sscanf(line, "%s %h %h %h %h", op_name, v0, v1, v2, v3);
                if (fields != 5) begin
                    $display("Operation line %0d in the vector file is incomplete",
                             op_q.size());
                    $display("=== FAIL ===");
                    $fatal(1, "bad vector file");
                end
                op_q.push_back(op_name);
                param_q.push_back(v0);
                data_q.push_back(v1);
                nupdt_q.push_back(v2);
                exp_q.push_back(v3);
            end
        end
        $fclose(fd);
        exp_status  = init_status;
        {exp_timeout, exp_enable, exp_addr, exp_anf} = init_image;
        cycle_limit = 8 + 200 * (op_q.size() + 1);

        repeat (8) @(posedge clock);
        reset <= 1'b0;
        // Post-reset read of the update register
        @(negedge clock);
        wait_idle();

        foreach (op_q[i]) begin
            if (op_q[i] == "read") begin
                run_read(i, param_q[i], nupdt_q[i][0], exp_q[i]);
            end else if (op_q[i] == "write") begin
                run_write(param_q[i], data_q[i]);
            end else if (op_q[i] == "reconfig") begin
                pulse_strobe(i, 1'b1);
            end else if (op_q[i] == "reset_timer") begin
                pulse_strobe(i, 1'b0);
            end else begin
                $display("Unknown operation in vector line %0d", i);
                $display("=== FAIL ===");
                $fatal(1, "bad vector file");
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/rsu_vectors.txt ====
# status wd_timeout wd_enable boot_addr anf (hex, initial update register)
15 a5c 1 12345678 0
# op param data ctl_nupdt expected (hex)
read 2 0 0 a5c
read 3 0 0 1
read 4 0 0 12345678
read 5 0 0 0
read 0 0 0 15
write 2 ffff3c7 0 0
read 2 0 0 3c7
read 4 0 0 12345678
write 3 0 0 0
read 3 0 0 0
read 2 0 0 3c7
write 4 cafe0001 0 0
read 4 0 0 cafe0001
read 3 0 0 0
write 5 3 0 0
read 5 0 0 1
read 4 0 0 cafe0001
read 2 0 1 3c7
read 1 0 0 0
read 6 0 0 0
read 7 0 0 0
write 0 1f 0 0
read 0 0 0 15
reconfig 0 0 0 0
reset_timer 0 0 0 0
read 2 0 0 3c7

// ==== sources.f ====
+incdir+include
src/rsu_pkg.sv
src/rsu_sequencer.sv
src/rsu_shadow_regs.sv
src/rsu_readout.sv
src/rsu_top.sv
bench/rsu_ru_model.sv
bench/rsu_checker.sv
bench/rsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rsu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= === PASS ===
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
